/* dfe_reg.f */
dfe_reg_pkg.sv
dfe_reset_sync.sv
dfe_bus_tracker.sv
dfe_sequencer.sv
dfe_field_map.sv
dfe_reg_top.sv
dfe_basic_model.sv
tb_dfe_reg.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_dfe_reg
RTL_TOP   = dfe_reg_top
FILELIST  = dfe_reg.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_dfe_reg.sv */
/*
 * testbench for the dfe register remapping controller
 * directed raw, field write, field read, address error and channel abort tests
 */
`timescale 1ns/1ns

module tb_dfe_reg
    import dfe_reg_pkg::*;
();

    localparam int RESET_STAGES = 7;
    // about 40 accesses of at most 4 bus cycles of ~12 clocks, wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              reset;
    uif_req_t          uif_req;
    logic              uif_chan_err;
    logic              uif_busy;
    logic [DATA_W-1:0] uif_rdata;
    logic              uif_addr_err;
    ctrl_cmd_t         ctrl_cmd;
    ctrl_rsp_t         ctrl_rsp;

    int          errors;
    int          checks;
    int          go_count;
    int          lock_count;
    int          cycle_count;
    logic [31:0] rand_state;
    logic [DATA_W-1:0] hw11, hw12, hw13, hw14, hw15;   // expected hardware registers

    dfe_reg_top #(
        .HIDDEN_REG_EN (1'b1),
        .RESET_STAGES  (RESET_STAGES)
    ) uut (
        .clk          (clk),
        .reset        (reset),
        .uif_req      (uif_req),
        .uif_chan_err (uif_chan_err),
        .uif_busy     (uif_busy),
        .uif_rdata    (uif_rdata),
        .uif_addr_err (uif_addr_err),
        .ctrl_cmd     (ctrl_cmd),
        .ctrl_rsp     (ctrl_rsp)
    );

    dfe_basic_model u_model (
        .clk   (clk),
        .reset (reset),
        .cmd   (ctrl_cmd),
        .rsp   (ctrl_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            go_count   <= 0;
            lock_count <= 0;
        end
        else if (ctrl_cmd.go)
        begin
            go_count <= go_count + 1;
            if (ctrl_cmd.lock)
                lock_count <= lock_count + 1;   // go that keeps the channel
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [DATA_W-1:0] next_word();
        rand_state = xorshift32(rand_state);
        return rand_state[DATA_W-1:0];
    endfunction

    // field write rules on the expected registers
    function automatic void apply_write(input logic [OFS_W-1:0] ofs,
                                        input logic [DATA_W-1:0] w);
        case (ofs)
            OFS_TAP1:
                hw11[3:0] = w[3:0];
            OFS_TAP2:
            begin
                hw11[6:4] = w[2:0];
                hw13[9]   = w[3];
            end
            OFS_TAP3:
            begin
                hw11[9:7] = w[2:0];
                hw13[10]  = w[3];
            end
            OFS_TAP4:
            begin
                hw11[12:10] = w[2:0];
                hw13[11]    = w[3];
            end
            OFS_TAP5:
            begin
                hw11[14:13] = w[1:0];
                hw13[12]    = w[2];
            end
            OFS_REF:
            begin
                hw13[15:13] = w[2:0];
                hw12[0]     = w[3];
                hw12[2:1]   = w[5:4];
            end
            OFS_STEP:
            begin
                hw13[3:1] = w[2:0];   // pien, s0d, s90d
                hw13[8:5] = w[6:3];
            end
            OFS_DFE12: hw12 = w;
            OFS_DFE13: hw13 = w;
            OFS_DFE14: hw14 = w;
            OFS_DFE15: hw15 = w;
            default: ;   // control writes touch nothing here
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [OFS_W-1:0] ofs);
        logic [DATA_W-1:0] r;
        r = '0;
        case (ofs)
            OFS_CTRL:  r[1:0] = {hw12[7], hw11[15]};
            OFS_TAP1:  r[3:0] = hw11[3:0];
            OFS_TAP2:  r[3:0] = {hw13[9], hw11[6:4]};
            OFS_TAP3:  r[3:0] = {hw13[10], hw11[9:7]};
            OFS_TAP4:  r[3:0] = {hw13[11], hw11[12:10]};
            OFS_TAP5:  r[2:0] = {hw13[12], hw11[14:13]};
            OFS_REF:   r[5:0] = {hw12[2:1], hw12[0], hw13[15:13]};
            OFS_STEP:  r[6:0] = {hw13[8:5], hw13[3:1]};
            OFS_DFE12: r = hw12;
            OFS_DFE13: r = hw13;
            OFS_DFE14: r = hw14;
            OFS_DFE15: r = hw15;
            default:   r = '0;
        endcase
        return r;
    endfunction

    function automatic int expected_gos(input uif_mode_e op_mode, input logic [OFS_W-1:0] ofs);
        int n;
        case (ofs)
            OFS_TAP1, OFS_STEP:
                n = (op_mode == MODE_WR) ? 2 : 1;
            OFS_TAP2, OFS_TAP3, OFS_TAP4, OFS_TAP5, OFS_REF:
                n = (op_mode == MODE_WR) ? 4 : 2;
            OFS_CTRL:
                n = (op_mode == MODE_WR) ? 0 : 2;
            OFS_DFE12, OFS_DFE13, OFS_DFE14, OFS_DFE15:
                n = 1;
            default:
                n = 0;
        endcase
        return n;
    endfunction

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp)
        begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // one user access, returns when busy has dropped and rdata is final
    task automatic run_access(input uif_mode_e op_mode, input logic [OFS_W-1:0] ofs,
                              input logic [DATA_W-1:0] wdata, output int gos,
                              output logic busy_seen);
        int start_count;
        @(posedge clk);
        start_count = go_count;
        uif_req <= '{go: 1'b1, mode: op_mode, addr: ofs, wdata: wdata};
        @(posedge clk);
        uif_req.go <= 1'b0;
        @(posedge clk);
        busy_seen = uif_busy;
        while (uif_busy)
            @(posedge clk);
        @(posedge clk);
        gos = go_count - start_count;
    endtask

    // single accesses, checking go counts, lock, busy and read data
    task automatic write_field(input logic [OFS_W-1:0] ofs, input logic [DATA_W-1:0] w);
        int   gos;
        int   lock_start;
        logic busy_seen;
        lock_start = lock_count;
        run_access(MODE_WR, ofs, w, gos, busy_seen);
        check_count($sformatf("write gos ofs %0d", ofs), expected_gos(MODE_WR, ofs), gos);
        // lock held on every go but the last
        check_count($sformatf("write locked gos ofs %0d", ofs),
                    expected_gos(MODE_WR, ofs) - 1, lock_count - lock_start);
        check_flag($sformatf("write busy ofs %0d", ofs), 1'b1, busy_seen);
        check_flag($sformatf("write addr_err ofs %0d", ofs), 1'b0, uif_addr_err);
        apply_write(ofs, w);
    endtask

    task automatic read_field(input logic [OFS_W-1:0] ofs);
        int   gos;
        int   lock_start;
        logic busy_seen;
        lock_start = lock_count;
        run_access(MODE_RD, ofs, '0, gos, busy_seen);
        check_count($sformatf("read gos ofs %0d", ofs), expected_gos(MODE_RD, ofs), gos);
        check_count($sformatf("read locked gos ofs %0d", ofs),
                    expected_gos(MODE_RD, ofs) - 1, lock_count - lock_start);
        check_flag($sformatf("read busy ofs %0d", ofs), 1'b1, busy_seen);
        check_data($sformatf("read data ofs %0d", ofs), expected_read(ofs), uif_rdata);
    endtask

    task automatic test_reset();
        for (int i = 0; i < RESET_STAGES + 4; i++)
        begin
            @(posedge clk);
            check_flag("reset busy", 1'b0, uif_busy);
            check_flag("reset bus go", 1'b0, ctrl_cmd.go);
            check_flag("reset lock", 1'b0, ctrl_cmd.lock);
            check_flag("reset addr_err", 1'b0, uif_addr_err);
            check_flag("reset opcode not rd", 1'b0, ctrl_cmd.opcode != OP_RD);
        end
    endtask

    task automatic test_raw_access();
        logic [OFS_W-1:0] ofs;
        for (ofs = OFS_DFE12; ofs <= OFS_DFE15; ofs++)
        begin
            write_field(ofs, next_word());
            read_field(ofs);
        end
    endtask

    task automatic test_field_write();
        logic [OFS_W-1:0] ofs;
        for (ofs = OFS_DFE12; ofs <= OFS_DFE13; ofs++)
            write_field(ofs, next_word());
        for (ofs = OFS_TAP1; ofs <= OFS_TAP5; ofs++)   // fills dfe11
            write_field(ofs, next_word());
        for (ofs = OFS_TAP2; ofs <= OFS_STEP; ofs++)
            write_field(ofs, next_word());
        read_field(OFS_DFE12);
        read_field(OFS_DFE13);
    endtask

    task automatic test_field_read();
        logic [OFS_W-1:0] ofs;
        for (ofs = OFS_CTRL; ofs <= OFS_STEP; ofs++)
            read_field(ofs);
    endtask

    task automatic test_bad_offset();
        logic [OFS_W-1:0] bad [3];
        int               gos;
        logic             busy_seen;
        bad = '{6'd12, 6'd33, 6'd63};
        for (int i = 0; i < 3; i++)
        begin
            run_access((i == 1) ? MODE_RD : MODE_WR, bad[i], next_word(), gos, busy_seen);
            check_flag($sformatf("bad ofs %0d addr_err", bad[i]), 1'b1, uif_addr_err);
            check_count($sformatf("bad ofs %0d gos", bad[i]), 0, gos);
            check_flag($sformatf("bad ofs %0d busy", bad[i]), 1'b0, busy_seen);
        end
        // control write is legal but starts nothing
        run_access(MODE_WR, OFS_CTRL, 16'h0003, gos, busy_seen);
        check_flag("ctrl write addr_err", 1'b0, uif_addr_err);
        check_count("ctrl write gos", 0, gos);
        check_flag("ctrl write busy", 1'b0, busy_seen);
    endtask

    task automatic test_chan_err();
        int   gos;
        logic busy_seen;
        @(posedge clk);
        uif_chan_err <= 1'b1;
        run_access(MODE_RD, OFS_TAP3, '0, gos, busy_seen);
        check_count("chan_err pair read gos", 1, gos);
        check_flag("chan_err busy seen", 1'b1, busy_seen);
        check_flag("chan_err lock after", 1'b0, ctrl_cmd.lock);   // channel released
        uif_chan_err <= 1'b0;
        read_field(OFS_TAP3);   // next request runs normally
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the DUT never finished", cycle_count);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        errors     = 0;
        checks     = 0;
        rand_state = 32'habfb;
        hw11 = '0;
        hw12 = '0;
        hw13 = '0;
        hw14 = '0;
        hw15 = '0;
        reset        <= 1'b1;
        uif_req      <= '0;
        uif_chan_err <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        test_reset();
        test_raw_access();
        test_field_write();
        test_field_read();
        test_bad_offset();
        test_chan_err();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* dfe_basic_model.sv */
/*
 * basic reconfiguration bus model for the testbench
 * holds dfe11 to dfe15 and answers each go after a random wait
 */
`timescale 1ns/1ns

module dfe_basic_model
    import dfe_reg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  ctrl_cmd_t cmd,
    output ctrl_rsp_t rsp
);

    logic [DATA_W-1:0] regs [0:7];   // dfe11..dfe15 sit at addr[2:0] = 3..7
    logic [2:0]        addr_q;
    logic [2:0]        wait_cnt;     // extra wait cycles, 0 to 5
    logic [31:0]       rand_state;
    logic [31:0]       rand_next;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign rand_next = xorshift32(rand_state);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
            addr_q     <= '0;
            wait_cnt   <= '0;
            rand_state <= 32'habfb;
            rsp        <= '0;
        end
        else if (cmd.go)
        begin
            rsp.pending <= 1'b1;   // wait rises on the go edge
            addr_q      <= cmd.addr[2:0];
            wait_cnt    <= 3'(rand_next % 32'd6);
            rand_state  <= rand_next;
            if ((cmd.opcode == OP_WR) && (cmd.addr >= ADDR_DFE11) && (cmd.addr <= ADDR_DFE15))
                regs[cmd.addr[2:0]] <= cmd.wdata;
        end
        else if (rsp.pending)
        begin
            if (wait_cnt == 3'd0)
            begin
                rsp.pending <= 1'b0;
                rsp.rdata   <= regs[addr_q];   // held until the next go
            end
            else
                wait_cnt <= wait_cnt - 3'd1;
        end
    end

endmodule

/* dfe_reg_top.sv */
/*
 * dfe register remapping controller
 * maps indirect user register accesses onto dfe hardware registers
 * through cycles on the basic reconfiguration bus
 */
`timescale 1ns/1ns

module dfe_reg_top
    import dfe_reg_pkg::*;
#(
    parameter bit HIDDEN_REG_EN = 1'b1,
    parameter int RESET_STAGES  = 7
) (
    input  logic              clk,
    input  logic              reset,
    input  uif_req_t          uif_req,
    input  logic              uif_chan_err,
    output logic              uif_busy,
    output logic [DATA_W-1:0] uif_rdata,
    output logic              uif_addr_err,
    output ctrl_cmd_t         ctrl_cmd,
    input  ctrl_rsp_t         ctrl_rsp
);

    logic              reset_sync;
    logic              done;
    logic              first_cycle;
    logic              rdata_load;
    logic              cmd_go;
    ctrl_op_e          cmd_opcode;
    logic              cmd_lock;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;

    dfe_reset_sync #(
        .RESET_STAGES (RESET_STAGES)
    ) u_reset_sync (
        .clk        (clk),
        .reset      (reset),
        .reset_sync (reset_sync)
    );

    dfe_bus_tracker u_bus_tracker (
        .clk         (clk),
        .reset_sync  (reset_sync),
        .cmd_go      (cmd_go),
        .rsp_pending (ctrl_rsp.pending),
        .done        (done)
    );

    dfe_sequencer #(
        .HIDDEN_REG_EN (HIDDEN_REG_EN)
    ) u_sequencer (
        .clk         (clk),
        .reset_sync  (reset_sync),
        .req         (uif_req),
        .chan_err    (uif_chan_err),
        .done        (done),
        .busy        (uif_busy),
        .addr_err    (uif_addr_err),
        .cmd_go      (cmd_go),
        .cmd_opcode  (cmd_opcode),
        .cmd_lock    (cmd_lock),
        .first_cycle (first_cycle),
        .rdata_load  (rdata_load)
    );

    dfe_field_map u_field_map (
        .clk         (clk),
        .req         (uif_req),
        .first_cycle (first_cycle),
        .rdata_load  (rdata_load),
        .rsp_rdata   (ctrl_rsp.rdata),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .uif_rdata   (uif_rdata)
    );

    assign ctrl_cmd = '{go:     cmd_go,
                        opcode: cmd_opcode,
                        lock:   cmd_lock,
                        addr:   cmd_addr,
                        wdata:  cmd_wdata};

endmodule

/* dfe_field_map.sv */
/*
 * dfe field map
 * picks the hardware address per cycle, merges user fields into the read
 * word for rmw writes and gathers hardware fields into the user read word
 */
`timescale 1ns/1ns

module dfe_field_map
    import dfe_reg_pkg::*;
(
    input  logic              clk,
    input  uif_req_t          req,
    input  logic              first_cycle,
    input  logic              rdata_load,
    input  logic [DATA_W-1:0] rsp_rdata,
    output logic [ADDR_W-1:0] cmd_addr,
    output logic [DATA_W-1:0] cmd_wdata,
    output logic [DATA_W-1:0] uif_rdata
);

    logic [ADDR_W-1:0] addr_sel;
    logic [DATA_W-1:0] wd;          // last read word with user fields merged in
    logic [DATA_W-1:0] rd;          // hardware fields in user positions
    logic [DATA_W-1:0] rdata_part;

    always_comb
    begin
        addr_sel = '0;
        if (first_cycle)
            case (req.addr)
                OFS_CTRL, OFS_TAP2, OFS_TAP3, OFS_TAP4, OFS_TAP5:
                    addr_sel = ADDR_DFE11;   // adapt, tap coefficients
                OFS_REF:
                    addr_sel = ADDR_DFE13;   // vref
                default:
                    addr_sel = '0;
            endcase
        else
            case (req.addr)
                OFS_TAP1:
                    addr_sel = ADDR_DFE11;
                OFS_CTRL, OFS_REF, OFS_DFE12:
                    addr_sel = ADDR_DFE12;   // pdb, cken, freq
                OFS_TAP2, OFS_TAP3, OFS_TAP4, OFS_TAP5, OFS_STEP, OFS_DFE13:
                    addr_sel = ADDR_DFE13;   // inversion, step
                OFS_DFE14:
                    addr_sel = ADDR_DFE14;
                OFS_DFE15:
                    addr_sel = ADDR_DFE15;
                default:
                    addr_sel = '0;
            endcase
    end

    always_comb
    begin
        wd = rsp_rdata;
        if (first_cycle)
            case (req.addr)
                OFS_TAP2:
                    wd[CTRL_RDFE_T2_2:CTRL_RDFE_T2_0] = req.wdata[UIF_RDFE_TAP_2:UIF_RDFE_TAP_0];
                OFS_TAP3:
                    wd[CTRL_RDFE_T3_2:CTRL_RDFE_T3_0] = req.wdata[UIF_RDFE_TAP_2:UIF_RDFE_TAP_0];
                OFS_TAP4:
                    wd[CTRL_RDFE_T4_2:CTRL_RDFE_T4_0] = req.wdata[UIF_RDFE_TAP_2:UIF_RDFE_TAP_0];
                OFS_TAP5:
                    wd[CTRL_RDFE_T5_1:CTRL_RDFE_T5_0] = req.wdata[UIF_RDFE_T5_1:UIF_RDFE_T5_0];
                OFS_REF:
                    wd[CTRL_RDFE_VREF_2:CTRL_RDFE_VREF_0] =
                        req.wdata[UIF_RDFE_VREF_2:UIF_RDFE_VREF_0];
                default:
                    wd = rsp_rdata;
            endcase
        else
            case (req.addr)
                OFS_TAP1:
                    wd[CTRL_RDFE_T1_3:CTRL_RDFE_T1_0] = req.wdata[UIF_RDFE_T1_3:UIF_RDFE_T1_0];
                OFS_TAP2:
                    wd[CTRL_RDFE_T2INV] = req.wdata[UIF_RDFE_TAPINV];
                OFS_TAP3:
                    wd[CTRL_RDFE_T3INV] = req.wdata[UIF_RDFE_TAPINV];
                OFS_TAP4:
                    wd[CTRL_RDFE_T4INV] = req.wdata[UIF_RDFE_TAPINV];
                OFS_TAP5:
                    wd[CTRL_RDFE_T5INV] = req.wdata[UIF_RDFE_T5INV];
                OFS_REF:
                begin
                    wd[CTRL_RDFE_CKEN] = req.wdata[UIF_RDFE_CKEN];
                    wd[CTRL_RDFE_FREQ_1:CTRL_RDFE_FREQ_0] =
                        req.wdata[UIF_RDFE_FREQ_1:UIF_RDFE_FREQ_0];
                end
                OFS_STEP:
                begin
                    wd[CTRL_RDFE_PIEN] = req.wdata[UIF_RDFE_PIEN];
                    wd[CTRL_RDFE_S0D]  = req.wdata[UIF_RDFE_S0D];
                    wd[CTRL_RDFE_S90D] = req.wdata[UIF_RDFE_S90D];
                    wd[CTRL_RDFE_STEP_3:CTRL_RDFE_STEP_0] =
                        req.wdata[UIF_RDFE_STEP_3:UIF_RDFE_STEP_0];
                end
                OFS_DFE12, OFS_DFE13, OFS_DFE14, OFS_DFE15:
                    wd = req.wdata;          // raw write, whole word
                default:
                    wd = rsp_rdata;
            endcase
    end

    always_comb
    begin
        rd = '0;
        if (first_cycle)
            case (req.addr)
                OFS_CTRL:
                    rd[UIF_RDFE_ADAPT] = rsp_rdata[CTRL_RDFE_ADAPT];
                OFS_TAP2:
                    rd[UIF_RDFE_TAP_2:UIF_RDFE_TAP_0] = rsp_rdata[CTRL_RDFE_T2_2:CTRL_RDFE_T2_0];
                OFS_TAP3:
                    rd[UIF_RDFE_TAP_2:UIF_RDFE_TAP_0] = rsp_rdata[CTRL_RDFE_T3_2:CTRL_RDFE_T3_0];
                OFS_TAP4:
                    rd[UIF_RDFE_TAP_2:UIF_RDFE_TAP_0] = rsp_rdata[CTRL_RDFE_T4_2:CTRL_RDFE_T4_0];
                OFS_TAP5:
                    rd[UIF_RDFE_T5_1:UIF_RDFE_T5_0] = rsp_rdata[CTRL_RDFE_T5_1:CTRL_RDFE_T5_0];
                OFS_REF:
                    rd[UIF_RDFE_VREF_2:UIF_RDFE_VREF_0] =
                        rsp_rdata[CTRL_RDFE_VREF_2:CTRL_RDFE_VREF_0];
                default:
                    rd = '0;
            endcase
        else
            case (req.addr)
                OFS_CTRL:
                    rd[UIF_RDFE_PDB] = rsp_rdata[CTRL_RDFE_PDB];
                OFS_TAP1:
                    rd[UIF_RDFE_T1_3:UIF_RDFE_T1_0] = rsp_rdata[CTRL_RDFE_T1_3:CTRL_RDFE_T1_0];
                OFS_TAP2:
                    rd[UIF_RDFE_TAPINV] = rsp_rdata[CTRL_RDFE_T2INV];
                OFS_TAP3:
                    rd[UIF_RDFE_TAPINV] = rsp_rdata[CTRL_RDFE_T3INV];
                OFS_TAP4:
                    rd[UIF_RDFE_TAPINV] = rsp_rdata[CTRL_RDFE_T4INV];
                OFS_TAP5:
                    rd[UIF_RDFE_T5INV] = rsp_rdata[CTRL_RDFE_T5INV];
                OFS_REF:
                begin
                    rd[UIF_RDFE_CKEN] = rsp_rdata[CTRL_RDFE_CKEN];
                    rd[UIF_RDFE_FREQ_1:UIF_RDFE_FREQ_0] =
                        rsp_rdata[CTRL_RDFE_FREQ_1:CTRL_RDFE_FREQ_0];
                end
                OFS_STEP:
                begin
                    rd[UIF_RDFE_PIEN] = rsp_rdata[CTRL_RDFE_PIEN];
                    rd[UIF_RDFE_S0D]  = rsp_rdata[CTRL_RDFE_S0D];
                    rd[UIF_RDFE_S90D] = rsp_rdata[CTRL_RDFE_S90D];
                    rd[UIF_RDFE_STEP_3:UIF_RDFE_STEP_0] =
                        rsp_rdata[CTRL_RDFE_STEP_3:CTRL_RDFE_STEP_0];
                end
                OFS_DFE12, OFS_DFE13, OFS_DFE14, OFS_DFE15:
                    rd = rsp_rdata;
                default:
                    rd = '0;
            endcase
    end

    always_ff @(posedge clk)
    begin
        cmd_addr   <= addr_sel;
        cmd_wdata  <= wd;
        rdata_part <= rd;
        if (req.go)
            uif_rdata <= '0;
        else if (rdata_load)
            uif_rdata <= uif_rdata | rdata_part;   // or in each half of a pair
    end

endmodule

/* dfe_sequencer.sv */
/*
 * dfe access sequencer
 * decodes user requests into read, rmw and raw cycles on the basic bus
 * and drives bus go, lock, opcode, busy and the address error flag
 */
`timescale 1ns/1ns

module dfe_sequencer
    import dfe_reg_pkg::*;
#(
    parameter bit HIDDEN_REG_EN = 1'b1
) (
    input  logic     clk,
    input  logic     reset_sync,
    input  uif_req_t req,
    input  logic     chan_err,
    input  logic     done,
    output logic     busy,
    output logic     addr_err,
    output logic     cmd_go,
    output ctrl_op_e cmd_opcode,
    output logic     cmd_lock,
    output logic     first_cycle,
    output logic     rdata_load
);

    seq_state_e state;
    seq_state_e next_state;
    seq_state_e start_state;
    logic       hidden_ofs;    // one of the raw dfe12..dfe15 offsets
    logic       legal_ofs;
    logic       go_d;          // bus go one clock early, gives address setup

    always_comb
    begin
        hidden_ofs  = (req.addr >= OFS_DFE12) && (req.addr <= OFS_DFE15);
        legal_ofs   = (req.addr <= OFS_STEP) || (hidden_ofs && HIDDEN_REG_EN);
        start_state = SEQ_IDLE;
        case (req.mode)
            MODE_WR:
                case (req.addr)
                    OFS_TAP1, OFS_STEP:
                        start_state = SEQ_WR1;       // single rmw
                    OFS_TAP2, OFS_TAP3, OFS_TAP4, OFS_TAP5, OFS_REF:
                        start_state = SEQ_WR2;       // double rmw
                    OFS_DFE12, OFS_DFE13, OFS_DFE14, OFS_DFE15:
                        if (HIDDEN_REG_EN)
                            start_state = SEQ_WW1;   // raw write
                    default:
                        start_state = SEQ_IDLE;      // control writes go to the cal block
                endcase
            MODE_RD:
                case (req.addr)
                    OFS_CTRL, OFS_TAP2, OFS_TAP3, OFS_TAP4, OFS_TAP5, OFS_REF:
                        start_state = SEQ_R2;
                    OFS_TAP1, OFS_STEP:
                        start_state = SEQ_R1;
                    OFS_DFE12, OFS_DFE13, OFS_DFE14, OFS_DFE15:
                        if (HIDDEN_REG_EN)
                            start_state = SEQ_R1;
                    default:
                        start_state = SEQ_IDLE;
                endcase
            default:
                start_state = SEQ_IDLE;
        endcase
    end

    always_comb
    begin
        next_state = state;
        case (state)
            SEQ_IDLE:
                if (req.go)
                    next_state = start_state;
            SEQ_WR2:
                if (done)
                    next_state = SEQ_WW2;
            SEQ_WW2:
                if (done)
                    next_state = SEQ_WR1;
            SEQ_WR1:
                if (done)
                    next_state = SEQ_WW1;
            SEQ_WW1:
                if (done)
                    next_state = SEQ_IDLE;
            SEQ_R2:
                if (done)
                    next_state = SEQ_R1;
            SEQ_R1:
                if (done)
                    next_state = SEQ_IDLE;
            default:
                next_state = SEQ_IDLE;
        endcase
        // bad channel, abort after the current cycle
        if (chan_err && done)
            next_state = SEQ_IDLE;
    end

    always_ff @(posedge clk or posedge reset_sync)
    begin
        if (reset_sync)
        begin
            state       <= SEQ_IDLE;
            busy        <= 1'b0;
            addr_err    <= 1'b0;
            go_d        <= 1'b0;
            cmd_go      <= 1'b0;
            cmd_opcode  <= OP_RD;
            cmd_lock    <= 1'b0;
            first_cycle <= 1'b0;
            rdata_load  <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            busy   <= (next_state != SEQ_IDLE);
            // accepted request, or a done that leads to another cycle
            go_d   <= (next_state != SEQ_IDLE) && ((state == SEQ_IDLE) || done);
            cmd_go <= go_d;

            cmd_lock    <= next_state inside {SEQ_WR2, SEQ_WW2, SEQ_WR1, SEQ_R2};
            first_cycle <= next_state inside {SEQ_WR2, SEQ_WW2, SEQ_R2};
            if (next_state inside {SEQ_WW2, SEQ_WW1})
                cmd_opcode <= OP_WR;
            else
                cmd_opcode <= OP_RD;

            rdata_load <= done && (state inside {SEQ_R2, SEQ_R1});

            if (req.go && (state == SEQ_IDLE))
                addr_err <= !legal_ofs;     // held until the next request
        end
    end

endmodule

/* dfe_bus_tracker.sv */
/*
 * basic bus done tracker
 * turns the bus wait level into a single done pulse per bus cycle
 */
`timescale 1ns/1ns

module dfe_bus_tracker
    import dfe_reg_pkg::*;
(
    input  logic clk,
    input  logic reset_sync,
    input  logic cmd_go,
    input  logic rsp_pending,
    output logic done
);

    done_state_e state;

    always_ff @(posedge clk or posedge reset_sync)
    begin
        if (reset_sync)
            state <= DONE_IDLE;
        else
        begin
            case (state)
                DONE_IDLE:
                    if (cmd_go)
                        state <= DONE_WAIT;
                DONE_WAIT:
                    if (!rsp_pending)   // cycle finished, rdata valid
                        state <= DONE_PULSE;
                DONE_PULSE:
                    state <= DONE_IDLE;
                default:
                    state <= DONE_IDLE;
            endcase
        end
    end

    assign done = (state == DONE_PULSE);

endmodule

/* dfe_reset_sync.sv */
/*
 * local reset synchronizer
 * holds the internal reset for RESET_STAGES clocks after the input reset drops
 */
`timescale 1ns/1ns

module dfe_reset_sync #(
    parameter int RESET_STAGES = 7
) (
    input  logic clk,
    input  logic reset,
    output logic reset_sync
);

    logic [RESET_STAGES-1:0] reset_ff;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            reset_ff <= '0;
        else
            reset_ff <= {reset_ff[RESET_STAGES-2:0], 1'b1};   // fill with ones
    end

    assign reset_sync = ~reset_ff[RESET_STAGES-1];

endmodule

/* dfe_reg_pkg.sv */
/*
 * dfe register remapping controller definitions
 * user offsets, hardware addresses, field bit positions and bus types
 */
package dfe_reg_pkg;

    localparam int DATA_W = 16;   // user and bus data
    localparam int ADDR_W = 12;   // basic bus address
    localparam int OFS_W  = 6;    // user register offset

    typedef enum logic [1:0] {
        MODE_RD = 2'd0,
        MODE_WR = 2'd1
    } uif_mode_e;

    typedef enum logic [2:0] {
        OP_RD = 3'd0,
        OP_WR = 3'd1
    } ctrl_op_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_WR2,    // read of first rmw pair
        SEQ_WW2,    // write of first rmw pair
        SEQ_WR1,
        SEQ_WW1,
        SEQ_R2,     // first of two reads
        SEQ_R1
    } seq_state_e;

    typedef enum logic [1:0] {
        DONE_IDLE,
        DONE_WAIT,
        DONE_PULSE
    } done_state_e;

    // user offsets
    localparam logic [OFS_W-1:0] OFS_CTRL  = 6'd0;
    localparam logic [OFS_W-1:0] OFS_TAP1  = 6'd1;
    localparam logic [OFS_W-1:0] OFS_TAP2  = 6'd2;
    localparam logic [OFS_W-1:0] OFS_TAP3  = 6'd3;
    localparam logic [OFS_W-1:0] OFS_TAP4  = 6'd4;
    localparam logic [OFS_W-1:0] OFS_TAP5  = 6'd5;
    localparam logic [OFS_W-1:0] OFS_REF   = 6'd6;
    localparam logic [OFS_W-1:0] OFS_STEP  = 6'd7;
    localparam logic [OFS_W-1:0] OFS_DFE12 = 6'd8;   // hidden raw registers
    localparam logic [OFS_W-1:0] OFS_DFE13 = 6'd9;
    localparam logic [OFS_W-1:0] OFS_DFE14 = 6'd10;
    localparam logic [OFS_W-1:0] OFS_DFE15 = 6'd11;

    localparam logic [ADDR_W-1:0] ADDR_DFE11 = 12'h00B;
    localparam logic [ADDR_W-1:0] ADDR_DFE12 = 12'h00C;
    localparam logic [ADDR_W-1:0] ADDR_DFE13 = 12'h00D;
    localparam logic [ADDR_W-1:0] ADDR_DFE14 = 12'h00E;
    localparam logic [ADDR_W-1:0] ADDR_DFE15 = 12'h00F;

    // hardware bits, dfe11
    localparam int CTRL_RDFE_T1_0   = 0;
    localparam int CTRL_RDFE_T1_3   = 3;
    localparam int CTRL_RDFE_T2_0   = 4;
    localparam int CTRL_RDFE_T2_2   = 6;
    localparam int CTRL_RDFE_T3_0   = 7;
    localparam int CTRL_RDFE_T3_2   = 9;
    localparam int CTRL_RDFE_T4_0   = 10;
    localparam int CTRL_RDFE_T4_2   = 12;
    localparam int CTRL_RDFE_T5_0   = 13;
    localparam int CTRL_RDFE_T5_1   = 14;
    localparam int CTRL_RDFE_ADAPT  = 15;
    // dfe12
    localparam int CTRL_RDFE_CKEN   = 0;
    localparam int CTRL_RDFE_FREQ_0 = 1;
    localparam int CTRL_RDFE_FREQ_1 = 2;
    localparam int CTRL_RDFE_PDB    = 7;   // power down, active low
    // dfe13
    localparam int CTRL_RDFE_PIEN   = 1;
    localparam int CTRL_RDFE_S0D    = 2;
    localparam int CTRL_RDFE_S90D   = 3;
    localparam int CTRL_RDFE_STEP_0 = 5;
    localparam int CTRL_RDFE_STEP_3 = 8;
    localparam int CTRL_RDFE_T2INV  = 9;
    localparam int CTRL_RDFE_T3INV  = 10;
    localparam int CTRL_RDFE_T4INV  = 11;
    localparam int CTRL_RDFE_T5INV  = 12;
    localparam int CTRL_RDFE_VREF_0 = 13;
    localparam int CTRL_RDFE_VREF_2 = 15;

    // user bits; taps 2 to 4 share one layout
    localparam int UIF_RDFE_ADAPT  = 0;
    localparam int UIF_RDFE_PDB    = 1;
    localparam int UIF_RDFE_T1_0   = 0;
    localparam int UIF_RDFE_T1_3   = 3;
    localparam int UIF_RDFE_TAP_0  = 0;
    localparam int UIF_RDFE_TAP_2  = 2;
    localparam int UIF_RDFE_TAPINV = 3;
    localparam int UIF_RDFE_T5_0   = 0;
    localparam int UIF_RDFE_T5_1   = 1;
    localparam int UIF_RDFE_T5INV  = 2;
    localparam int UIF_RDFE_VREF_0 = 0;
    localparam int UIF_RDFE_VREF_2 = 2;
    localparam int UIF_RDFE_CKEN   = 3;
    localparam int UIF_RDFE_FREQ_0 = 4;
    localparam int UIF_RDFE_FREQ_1 = 5;
    localparam int UIF_RDFE_PIEN   = 0;
    localparam int UIF_RDFE_S0D    = 1;
    localparam int UIF_RDFE_S90D   = 2;
    localparam int UIF_RDFE_STEP_0 = 3;
    localparam int UIF_RDFE_STEP_3 = 6;

    typedef struct packed {
        logic              go;      // one-cycle start, only while not busy
        uif_mode_e         mode;
        logic [OFS_W-1:0]  addr;
        logic [DATA_W-1:0] wdata;
    } uif_req_t;

    typedef struct packed {
        logic              go;
        ctrl_op_e          opcode;
        logic              lock;    // keep the channel between paired cycles
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } ctrl_cmd_t;

    typedef struct packed {
        logic              pending; // bus wait
        logic [DATA_W-1:0] rdata;
    } ctrl_rsp_t;

endpackage
